/* src/ads_pkg.sv */
`default_nettype none

package ads_pkg;

    localparam int QUARTER_CLKS = 25;         // clocks per quarter scl bit
    localparam int DIV_W        = $clog2(QUARTER_CLKS);
    localparam int POLL_CLKS    = 20000;
    localparam int POLL_W       = $clog2(POLL_CLKS);

    localparam logic [6:0] DEV_ADDR = 7'h48;
    localparam logic [7:0] REG_CONV = 8'h00;  // conversion result register

    // apb register map
    localparam logic [7:0] CTRL_OFS   = 8'h00;
    localparam logic [7:0] PTR_OFS    = 8'h04;
    localparam logic [7:0] WDATA_OFS  = 8'h08;
    localparam logic [7:0] STATUS_OFS = 8'h0C;
    localparam logic [7:0] RDATA_OFS  = 8'h10;
    localparam logic [7:0] SAMPLE_OFS = 8'h14;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } i2c_op_e;

    typedef enum logic [2:0] {
        IDLE,
        START,
        SEND_BYTE,
        GET_ACK,
        RECV_BYTE,
        SEND_ACK,
        RESTART,
        STOP
    } phase_e;

endpackage

`default_nettype wire

/* src/i2c_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface i2c_req_if import ads_pkg::*; ();

    logic        req;
    i2c_op_e     op;
    logic [7:0]  ptr;    // device register pointer
    logic [15:0] wdata;
    logic        done;   // one cycle pulse
    logic        nack;
    logic [15:0] rdata;

    modport requester (
        output req, op, ptr, wdata,
        input  done, nack, rdata
    );

    modport arbiter (
        input  req, op, ptr, wdata,
        output done, nack, rdata
    );

    // the engine sits on the serving end, same as the arbiter
    modport engine (
        input  req, op, ptr, wdata,
        output done, nack, rdata
    );

endinterface

`default_nettype wire

/* src/i2c_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_engine import ads_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    i2c_req_if.engine    eng,
    input  wire logic    scl_in,
    input  wire logic    sda_in,
    output logic         scl_low,
    output logic         sda_low
);

    phase_e      phase;
    logic [DIV_W-1:0] div;
    logic        tick;
    logic [1:0]  q;          // quarter within the current bit
    logic [2:0]  bitcnt;
    logic [2:0]  idx;        // byte index within the transfer
    logic [7:0]  tx_byte;
    logic [15:0] rx;
    logic        ack_hi;
    logic        nack_r;
    logic        done_r;

    assign tick = (phase != IDLE) && (div == DIV_W'(QUARTER_CLKS - 1));

    // byte 2 is the data msb on a write, the read address after a restart
    always_comb begin
        case (idx)
            3'd0:    tx_byte = {DEV_ADDR, 1'b0};
            3'd1:    tx_byte = eng.ptr;
            3'd2:    tx_byte = (eng.op == OP_READ) ? {DEV_ADDR, 1'b1} : eng.wdata[15:8];
            default: tx_byte = eng.wdata[7:0];
        endcase
    end

    assign eng.done  = done_r;
    assign eng.nack  = nack_r;
    assign eng.rdata = rx;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= IDLE;
            div     <= '0;
            q       <= 2'd0;
            bitcnt  <= 3'd0;
            idx     <= 3'd0;
            ack_hi  <= 1'b0;
            nack_r  <= 1'b0;
            done_r  <= 1'b0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (phase == IDLE || tick)
                div <= '0;
            else
                div <= div + 1'b1;

            if (phase == IDLE) begin
                q <= 2'd0;
                if (eng.req && !done_r) begin   // req is still up in the done cycle
                    phase  <= START;
                    nack_r <= 1'b0;
                    idx    <= 3'd0;
                    bitcnt <= 3'd7;
                end
            end else if (tick) begin
                q <= q + 1'b1;
                case (phase)
                    START: begin
                        case (q)
                            2'd0: sda_low <= 1'b1;   // sda falls with scl high
                            2'd2: scl_low <= 1'b1;
                            2'd3: phase <= SEND_BYTE;
                            default: ;
                        endcase
                    end

                    SEND_BYTE: begin
                        case (q)
                            2'd0: sda_low <= ~tx_byte[bitcnt];
                            2'd1: scl_low <= 1'b0;
                            2'd2: scl_low <= 1'b1;
                            default: begin
                                if (bitcnt == 3'd0)
                                    phase <= GET_ACK;
                                else
                                    bitcnt <= bitcnt - 1'b1;
                            end
                        endcase
                    end

                    GET_ACK: begin
                        case (q)
                            2'd0: sda_low <= 1'b0;   // hand sda to the target
                            2'd1: scl_low <= 1'b0;
                            2'd2: begin
                                ack_hi  <= sda_in;
                                scl_low <= 1'b1;
                            end
                            default: begin
                                bitcnt <= 3'd7;
                                if (ack_hi) begin
                                    nack_r <= 1'b1;
                                    phase  <= STOP;
                                end else if (eng.op == OP_READ && idx == 3'd1) begin
                                    phase <= RESTART;
                                end else if (eng.op == OP_READ && idx == 3'd2) begin
                                    idx   <= 3'd3;
                                    phase <= RECV_BYTE;
                                end else if (idx == 3'd3) begin
                                    phase <= STOP;
                                end else begin
                                    idx   <= idx + 1'b1;
                                    phase <= SEND_BYTE;
                                end
                            end
                        endcase
                    end

                    RESTART: begin
                        case (q)
                            2'd0: sda_low <= 1'b0;
                            2'd1: scl_low <= 1'b0;
                            2'd2: sda_low <= 1'b1;   // repeated start
                            default: begin
                                scl_low <= 1'b1;
                                idx     <= 3'd2;
                                phase   <= SEND_BYTE;
                            end
                        endcase
                    end

                    RECV_BYTE: begin
                        case (q)
                            2'd0: sda_low <= 1'b0;
                            2'd1: scl_low <= 1'b0;
                            2'd2: begin
                                rx      <= {rx[14:0], sda_in};
                                scl_low <= 1'b1;
                            end
                            default: begin
                                if (bitcnt == 3'd0)
                                    phase <= SEND_ACK;
                                else
                                    bitcnt <= bitcnt - 1'b1;
                            end
                        endcase
                    end

                    SEND_ACK: begin
                        case (q)
                            2'd0: sda_low <= (idx == 3'd3);   // nack the last byte
                            2'd1: scl_low <= 1'b0;
                            2'd2: scl_low <= 1'b1;
                            default: begin
                                bitcnt <= 3'd7;
                                if (idx == 3'd3) begin
                                    idx   <= 3'd4;
                                    phase <= RECV_BYTE;
                                end else begin
                                    phase <= STOP;
                                end
                            end
                        endcase
                    end

                    STOP: begin
                        case (q)
                            2'd0: sda_low <= 1'b1;
                            2'd1: scl_low <= 1'b0;
                            2'd2: begin
                                if (scl_in)
                                    sda_low <= 1'b0;
                                else
                                    q <= q;              // target stretching scl
                            end
                            default: begin
                                phase  <= IDLE;
                                done_r <= 1'b1;
                            end
                        endcase
                    end

                    default: phase <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  wire logic    clk,
    input  wire logic    rst,
    i2c_req_if.arbiter   host,
    i2c_req_if.arbiter   poll,
    i2c_req_if.requester eng
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_HOST,
        OWN_POLL
    } owner_e;

    owner_e owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (host.req)
                        owner <= OWN_HOST;   // host wins a tie
                    else if (poll.req)
                        owner <= OWN_POLL;
                end
                default: begin
                    if (eng.done)
                        owner <= OWN_NONE;
                end
            endcase
        end
    end

    // request fields follow the owner
    assign eng.req   = (owner == OWN_HOST) ? host.req :
                       (owner == OWN_POLL) ? poll.req : 1'b0;
    assign eng.op    = (owner == OWN_POLL) ? poll.op    : host.op;
    assign eng.ptr   = (owner == OWN_POLL) ? poll.ptr   : host.ptr;
    assign eng.wdata = (owner == OWN_POLL) ? poll.wdata : host.wdata;

    // completion goes back to the owner only
    assign host.done  = eng.done && (owner == OWN_HOST);
    assign host.nack  = eng.nack && (owner == OWN_HOST);
    assign host.rdata = (owner == OWN_HOST) ? eng.rdata : 16'd0;
    assign poll.done  = eng.done && (owner == OWN_POLL);
    assign poll.nack  = eng.nack && (owner == OWN_POLL);
    assign poll.rdata = (owner == OWN_POLL) ? eng.rdata : 16'd0;

endmodule

`default_nettype wire

/* src/apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_regs import ads_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    i2c_req_if.requester     host,
    input  wire logic [15:0] sample,
    input  wire logic        sample_valid,
    output logic             poll_en
);

    logic        wr_en;
    logic        start_hit;
    logic        busy;
    logic        nack_r;
    i2c_op_e     op_r;
    logic [7:0]  ptr_r;
    logic [15:0] wdata_r;
    logic [15:0] rdata_r;

    assign wr_en     = psel && penable && pwrite;
    assign start_hit = wr_en && (paddr == CTRL_OFS) && pwdata[0];

    assign pready  = 1'b1;   // zero wait states
    // no start, and no change to the request fields, while a transfer runs
    assign pslverr = busy && (start_hit ||
                     (wr_en && (paddr == PTR_OFS || paddr == WDATA_OFS)));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            nack_r  <= 1'b0;
            poll_en <= 1'b0;
            op_r    <= OP_WRITE;
            ptr_r   <= 8'd0;
            wdata_r <= 16'd0;
        end else begin
            if (wr_en && paddr == CTRL_OFS)
                poll_en <= pwdata[2];
            if (wr_en && !busy && paddr == PTR_OFS)
                ptr_r <= pwdata[7:0];
            if (wr_en && !busy && paddr == WDATA_OFS)
                wdata_r <= pwdata[15:0];

            if (start_hit && !busy) begin
                busy   <= 1'b1;
                nack_r <= 1'b0;
                op_r   <= pwdata[1] ? OP_READ : OP_WRITE;
            end else if (host.done) begin
                busy   <= 1'b0;   // req drops the cycle after done
                nack_r <= host.nack;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host.done)
            rdata_r <= host.rdata;
    end

    assign host.req   = busy;
    assign host.op    = op_r;
    assign host.ptr   = ptr_r;
    assign host.wdata = wdata_r;

    always_comb begin
        case (paddr)
            CTRL_OFS:   prdata = {29'd0, poll_en, op_r, busy};
            PTR_OFS:    prdata = {24'd0, ptr_r};
            WDATA_OFS:  prdata = {16'd0, wdata_r};
            STATUS_OFS: prdata = {29'd0, sample_valid, nack_r, busy};
            RDATA_OFS:  prdata = {16'd0, rdata_r};
            SAMPLE_OFS: prdata = {16'd0, sample};
            default:    prdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* src/conv_poller.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_poller import ads_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    poll_en,
    i2c_req_if.requester poll,
    output logic [15:0]  sample,
    output logic         sample_valid
);

    logic [POLL_W-1:0] cnt;
    logic              req_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt          <= '0;
            req_r        <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            if (!poll_en || cnt == POLL_W'(POLL_CLKS - 1))
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            // first read goes out right after enable
            if (poll_en && cnt == '0 && !req_r)
                req_r <= 1'b1;
            else if (poll.done)
                req_r <= 1'b0;

            if (poll.done && !poll.nack)
                sample_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (poll.done && !poll.nack)
            sample <= poll.rdata;
    end

    assign poll.req   = req_r;
    assign poll.op    = OP_READ;
    assign poll.ptr   = REG_CONV;
    assign poll.wdata = 16'd0;   // unused on reads

endmodule

`default_nettype wire

/* src/ads_i2c_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ads_i2c_top (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    input  wire logic        scl_in,
    input  wire logic        sda_in,
    output logic             scl_low,
    output logic             sda_low
);

    logic [15:0] sample;
    logic        sample_valid;
    logic        poll_en;

    i2c_req_if host_req ();
    i2c_req_if poll_req ();
    i2c_req_if eng_req ();

    apb_regs apb_regs_i (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .host         (host_req.requester),
        .sample       (sample),
        .sample_valid (sample_valid),
        .poll_en      (poll_en)
    );

    conv_poller conv_poller_i (
        .clk          (clk),
        .rst          (rst),
        .poll_en      (poll_en),
        .poll         (poll_req.requester),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    bus_arbiter bus_arbiter_i (
        .clk  (clk),
        .rst  (rst),
        .host (host_req.arbiter),
        .poll (poll_req.arbiter),
        .eng  (eng_req.requester)
    );

    i2c_engine i2c_engine_i (
        .clk     (clk),
        .rst     (rst),
        .eng     (eng_req.engine),
        .scl_in  (scl_in),
        .sda_in  (sda_in),
        .scl_low (scl_low),
        .sda_low (sda_low)
    );

endmodule

`default_nettype wire

/* verification/ads_model.sv */
`timescale 1ns/1ns
`default_nettype none

module ads_model import ads_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        scl,
    input  wire logic        sda,
    output logic             sda_low,
    input  wire logic        nack_addr,    // refuse the address byte
    input  wire logic        preload_en,
    input  wire logic [7:0]  preload_ptr,
    input  wire logic [15:0] preload_val
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_MACK
    } mstate_e;

    mstate_e     state;
    logic [15:0] regs [256];
    logic        scl_q;
    logic        sda_q;
    logic [3:0]  bits;
    logic [7:0]  shreg;
    logic [7:0]  tx_sh;
    logic [1:0]  byte_no;   // addr, ptr, data msb, data lsb
    logic        rw;
    logic        rd_byte;
    logic        mack;
    logic [7:0]  ptr;
    logic [7:0]  hi;

    initial begin
        for (int i = 0; i < 256; i++)
            regs[i] = {8'(i) ^ 8'h5A, ~8'(i)};
    end

    always @(posedge clk) begin
        if (rst) begin
            state   <= M_IDLE;
            scl_q   <= 1'b1;
            sda_q   <= 1'b1;
            sda_low <= 1'b0;
            bits    <= 4'd0;
            byte_no <= 2'd0;
            rw      <= 1'b0;
            rd_byte <= 1'b0;
            mack    <= 1'b0;
            ptr     <= 8'd0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (preload_en)
                regs[preload_ptr] <= preload_val;

            if (scl && scl_q && sda_q && !sda) begin   // start or repeated start
                state   <= M_RX;
                bits    <= 4'd0;
                byte_no <= 2'd0;
                sda_low <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin
                state   <= M_IDLE;   // stop
                sda_low <= 1'b0;
            end else if (scl && !scl_q) begin
                if (state == M_RX) begin
                    shreg <= {shreg[6:0], sda};
                    bits  <= bits + 4'd1;
                end else if (state == M_MACK) begin
                    mack <= !sda;
                end
            end else if (!scl && scl_q) begin
                case (state)
                    M_RX: begin
                        if (bits == 4'd8) begin
                            bits    <= 4'd0;
                            byte_no <= byte_no + 2'd1;
                            state   <= M_ACK;
                            sda_low <= 1'b1;
                            case (byte_no)
                                2'd0: begin
                                    rw <= shreg[0];
                                    if (shreg[7:1] != DEV_ADDR || nack_addr) begin
                                        state   <= M_IDLE;
                                        sda_low <= 1'b0;
                                    end
                                end
                                2'd1: ptr <= shreg;
                                2'd2: hi <= shreg;
                                default: regs[ptr] <= {hi, shreg};
                            endcase
                        end
                    end
                    M_ACK: begin
                        if (rw) begin
                            tx_sh   <= regs[ptr][15:8];
                            sda_low <= ~regs[ptr][15];
                            rd_byte <= 1'b0;
                            bits    <= 4'd0;
                            state   <= M_TX;
                        end else begin
                            sda_low <= 1'b0;
                            state   <= M_RX;
                        end
                    end
                    M_TX: begin
                        bits <= bits + 4'd1;
                        if (bits == 4'd7) begin
                            sda_low <= 1'b0;   // master acks next
                            state   <= M_MACK;
                        end else begin
                            sda_low <= ~tx_sh[6];
                            tx_sh   <= {tx_sh[6:0], 1'b0};
                        end
                    end
                    M_MACK: begin
                        if (mack && !rd_byte) begin
                            tx_sh   <= regs[ptr][7:0];
                            sda_low <= ~regs[ptr][7];
                            rd_byte <= 1'b1;
                            bits    <= 4'd0;
                            state   <= M_TX;
                        end else begin
                            sda_low <= 1'b0;
                            state   <= M_IDLE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top import ads_pkg::*; ();

    // start, five 9-bit bytes, restart and stop, four ticks each
    localparam int READ_TICKS    = 4 + 5 * 9 * 4 + 4 + 4;
    localparam int READ_CLKS     = READ_TICKS * QUARTER_CLKS;
    localparam int N_XFERS       = 6;   // five host transfers and one poller read
    localparam int WATCHDOG_CLKS = 10 * N_XFERS * READ_CLKS;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl_low;
    logic        sda_low;
    logic        model_sda_low;
    logic        nack_addr;
    logic        preload_en;
    logic [7:0]  preload_ptr;
    logic [15:0] preload_val;
    logic [31:0] rng;
    wire         scl;
    wire         sda;

    assign scl = ~scl_low;                     // target never stretches
    assign sda = ~(sda_low | model_sda_low);   // wired-and

    ads_i2c_top ads_i2c_top_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl_in  (scl),
        .sda_in  (sda),
        .scl_low (scl_low),
        .sda_low (sda_low)
    );

    ads_model model_i (
        .clk         (clk),
        .rst         (rst),
        .scl         (scl),
        .sda         (sda),
        .sda_low     (model_sda_low),
        .nack_addr   (nack_addr),
        .preload_en  (preload_en),
        .preload_ptr (preload_ptr),
        .preload_val (preload_val)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
            else abort_run($sformatf("error: t=%0t %s got 0x%0h expected 0x%0h",
                                     $time, name, got, exp));
    endtask

    always_comb begin
        pready_high: assert (rst || pready)
            else abort_run("pready dropped, an APB access would stall");
    end

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        !pslverr || (psel && penable))
        else abort_run("pslverr raised outside an APB access phase");

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdat;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);   // access phase, outputs settled
        rdat = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic preload_reg(input logic [7:0] p, input logic [15:0] v);
        @(posedge clk);
        preload_en  <= 1'b1;
        preload_ptr <= p;
        preload_val <= v;
        @(posedge clk);
        preload_en  <= 1'b0;
    endtask

    task automatic load_request(input logic [7:0] p, input logic [15:0] v);
        logic err;
        apb_write(PTR_OFS, {24'd0, p}, err);
        check_eq("pslverr", 32'(err), 32'd0);
        apb_write(WDATA_OFS, {16'd0, v}, err);
        check_eq("pslverr", 32'(err), 32'd0);
    endtask

    task automatic wait_idle(output logic [31:0] status);
        status = 32'd1;
        while (status[0])
            apb_read(STATUS_OFS, status);
    endtask

    task automatic start_and_wait(input logic [31:0] ctrl, output logic [31:0] status);
        logic err;
        apb_write(CTRL_OFS, ctrl, err);
        check_eq("pslverr", 32'(err), 32'd0);
        wait_idle(status);
    endtask

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        abort_run("timeout, the transfers did not finish in time");
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [7:0]  p;
        logic [15:0] v;
        logic [15:0] old;
        logic [15:0] conv;

        rng         = 32'd62;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 8'd0;
        pwdata      = 32'd0;
        nack_addr   = 1'b0;
        preload_en  = 1'b0;
        preload_ptr = 8'd0;
        preload_val = 16'd0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        apb_read(STATUS_OFS, rd);
        check_eq("status", rd, 32'd0);
        check_eq("scl_low", 32'(scl_low), 32'd0);
        check_eq("sda_low", 32'(sda_low), 32'd0);

        // plain write
        rng = xorshift32(rng);
        p   = rng[7:0];
        v   = rng[23:8];
        load_request(p, v);
        start_and_wait(32'h1, rd);
        check_eq("status.nack", 32'(rd[1]), 32'd0);
        check_eq("model.regs", 32'(model_i.regs[p]), 32'(v));

        // read back a preloaded register
        rng = xorshift32(rng);
        p   = rng[15:8];
        v   = rng[31:16];
        preload_reg(p, v);
        load_request(p, 16'd0);
        start_and_wait(32'h3, rd);
        check_eq("status.nack", 32'(rd[1]), 32'd0);
        apb_read(RDATA_OFS, rd);
        check_eq("rdata", rd, 32'(v));

        // address nack
        rng = xorshift32(rng);
        p   = rng[7:0];
        old = model_i.regs[p];
        @(posedge clk);
        nack_addr <= 1'b1;
        load_request(p, ~old);
        start_and_wait(32'h1, rd);
        check_eq("status.nack", 32'(rd[1]), 32'd1);
        check_eq("model.regs", 32'(model_i.regs[p]), 32'(old));
        @(posedge clk);
        nack_addr <= 1'b0;

        // start again while busy
        rng = xorshift32(rng);
        p   = rng[23:16];
        v   = rng[15:0];
        load_request(p, v);
        apb_write(CTRL_OFS, 32'h1, err);
        check_eq("pslverr", 32'(err), 32'd0);
        apb_write(CTRL_OFS, 32'h3, err);
        check_eq("pslverr", 32'(err), 32'd1);
        wait_idle(rd);
        check_eq("status.nack", 32'(rd[1]), 32'd0);
        check_eq("model.regs", 32'(model_i.regs[p]), 32'(v));

        // poller runs, host write queues behind it
        rng  = xorshift32(rng);
        conv = rng[15:0];
        preload_reg(REG_CONV, conv);
        apb_write(CTRL_OFS, 32'h4, err);
        check_eq("pslverr", 32'(err), 32'd0);
        rng = xorshift32(rng);
        p   = rng[7:0] | 8'h01;   // stay off the conversion register
        v   = rng[31:16];
        load_request(p, v);
        start_and_wait(32'h5, rd);
        check_eq("status.nack", 32'(rd[1]), 32'd0);
        check_eq("model.regs", 32'(model_i.regs[p]), 32'(v));
        rd = 32'd0;
        while (!rd[2])
            apb_read(STATUS_OFS, rd);
        apb_read(SAMPLE_OFS, rd);
        check_eq("sample", rd, 32'(conv));

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/ads_pkg.sv
src/i2c_req_if.sv
src/i2c_engine.sv
src/bus_arbiter.sv
src/apb_regs.sv
src/conv_poller.sv
src/ads_i2c_top.sv
verification/ads_model.sv
verification/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_top

out=$(./obj_dir/Vtb_top 2>&1) || true
printf '%s\n' "$out"
echo "$out" | grep -q "^PASS: all tests$"
